//--- vc_req_cfg.svh
`ifndef VC_REQ_CFG_SVH
`define VC_REQ_CFG_SVH

// router geometry

// virtual channels per port
`define VC_NUM 4

// local plus four mesh neighbours
`define PORT_NUM 5

// one-hot of the escape VC within a port
`define ESCAPE_VC_MASK 4'b1000

// APB register map

`define APB_ADDR_W 4

// quadrant pre-selection, bit {x_plus,y_plus} set means go y first
`define PRESEL_ADDR 4'd0

// bit 0 selects full adaptive, clear means partial adaptive
`define CTRL_ADDR 4'd4

`endif

//--- vc_req_pkg.sv
`include "vc_req_cfg.svh"

package vc_req_pkg;

    // router port index
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_e;

    // one bit per VC of a port
    typedef logic [`VC_NUM-1:0] vc_mask_t;

    // remaining hops of a packet
    // both hop bits clear means the destination is this router
    typedef struct packed {
        logic x_plus;
        logic y_plus;
        logic x_hop;
        logic y_hop;
    } route_t;

    // output port one-hot with the receiving port removed
    typedef logic [`PORT_NUM-2:0] dest_out_t;

    // neighbour availability as seen from one input port
    // own direction is replaced by local availability
    typedef struct packed {
        vc_mask_t x_plus;
        vc_mask_t x_minus;
        vc_mask_t y_plus;
        vc_mask_t y_minus;
    } other_avail_t;

    // indexed by {x_plus,y_plus}, 1 picks y
    typedef logic [3:0] presel_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

//--- presel_regs.sv
`timescale 1ns/100ps

`include "vc_req_cfg.svh"

module presel_regs
    import vc_req_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output presel_t  presel,
    output logic     full_adaptive
);

    logic access;
    logic wr_en;
    logic rd_en;
    logic hit_presel;
    logic hit_ctrl;
    logic unmapped;

    presel_t presel_q;
    logic    full_adaptive_q;

    // access phase of an APB transfer, no wait states
    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;
    assign rd_en  = access & ~apb_req.pwrite;

    // address decode
    assign hit_presel = (apb_req.paddr == `PRESEL_ADDR);
    assign hit_ctrl   = (apb_req.paddr == `CTRL_ADDR);
    assign unmapped   = ~hit_presel & ~hit_ctrl;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            presel_q        <= '0;
            full_adaptive_q <= 1'b1;
        end else begin
            if (wr_en && hit_presel) begin
                presel_q <= apb_req.pwdata[3:0];
            end
            if (wr_en && hit_ctrl) begin
                full_adaptive_q <= apb_req.pwdata[0];
            end
        end
    end

    // read mux and response
    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & unmapped;
        if (rd_en) begin
            if (hit_presel) begin
                apb_rsp.prdata[3:0] = presel_q;
            end else if (hit_ctrl) begin
                apb_rsp.prdata[0] = full_adaptive_q;
            end
        end
    end

    assign presel        = presel_q;
    assign full_adaptive = full_adaptive_q;

endmodule

//--- port_selector.sv
`timescale 1ns/100ps

`include "vc_req_cfg.svh"

module port_selector
    import vc_req_pkg::*;
#(
    parameter int unsigned SW_LOC = 0
) (
    input  logic      clk,
    input  logic      reset,
    input  presel_t   port_presel,
    input  logic      presel_ld,
    input  logic      swap_presel,
    input  route_t    route,
    output logic      sel,
    output logic      y_evc_forbidden,
    output dest_out_t dest_port_out
);

    // north and south inputs send a local packet through the y side
    localparam bit LOCAL_SEL = (SW_LOC == int'(NORTH)) || (SW_LOC == int'(SOUTH));

    presel_t presel_final;
    presel_t presel_latched;

    logic both_dir;
    logic is_local;
    logic sel_pre;
    logic sel_single;

    logic [`PORT_NUM-1:0] portout;

    // escape sender with no adaptive VC flips its quadrant choice
    assign presel_final = swap_presel ? ~port_presel : port_presel;

    // hold the choice once the OVC is assigned
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            presel_latched <= '0;
        end else if (presel_ld) begin
            presel_latched <= presel_final;
        end
    end

    assign both_dir = route.x_hop & route.y_hop;
    assign is_local = ~route.x_hop & ~route.y_hop;

    // quadrant bit of the latched pre-selection
    assign sel_pre = presel_latched[{route.x_plus, route.y_plus}];

    assign sel_single = LOCAL_SEL ? (route.y_hop | is_local) : route.y_hop;

    assign sel = both_dir ? sel_pre : sel_single;

    // XY escape subfunction, no escape VC in y while x is still open
    assign y_evc_forbidden = both_dir;

    // five-port one-hot of the chosen output
    always_comb begin
        portout = '0;
        if (is_local) begin
            portout[LOCAL] = 1'b1;
        end else if (sel) begin
            portout[NORTH] = route.y_plus;
            portout[SOUTH] = ~route.y_plus;
        end else begin
            portout[EAST] = route.x_plus;
            portout[WEST] = ~route.x_plus;
        end
    end

    // drop the bit of the receiving port
    always_comb begin
        for (int k = 0; k < `PORT_NUM - 1; k++) begin
            if (k < SW_LOC) begin
                dest_port_out[k] = portout[k];
            end else begin
                dest_port_out[k] = portout[k+1];
            end
        end
    end

endmodule

//--- ovc_request_mask.sv
`timescale 1ns/100ps

`include "vc_req_cfg.svh"

module ovc_request_mask
    import vc_req_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  other_avail_t other_avail,
    input  route_t       route,
    input  logic         sel,
    input  logic         y_evc_forbidden,
    input  logic         full_adaptive,
    input  vc_mask_t     candidate_ovc,
    input  logic         pending_request,
    output vc_mask_t     masked_ovc_request,
    output logic         swap_presel
);

    localparam vc_mask_t ESC_MASK = `ESCAPE_VC_MASK;

    vc_mask_t avail_x;
    vc_mask_t avail_y;
    vc_mask_t candidate_y;
    vc_mask_t request_gate;
    vc_mask_t masked_x;
    vc_mask_t masked_y;

    logic avc_unavailable;
    logic swap_next;
    logic swap_q;

    // plus or minus neighbour per dimension
    assign avail_x = route.x_plus ? other_avail.x_plus : other_avail.x_minus;
    assign avail_y = route.y_plus ? other_avail.y_plus : other_avail.y_minus;

    // escape VC in y is off limits while the packet may still go x
    assign candidate_y = (full_adaptive && y_evc_forbidden) ?
                         (candidate_ovc & ~ESC_MASK) : candidate_ovc;

    assign request_gate = {`VC_NUM{pending_request}};

    assign masked_x = avail_x & candidate_ovc & request_gate;
    assign masked_y = avail_y & candidate_y & request_gate;

    assign masked_ovc_request = sel ? masked_y : masked_x;

    // nothing adaptive left on the chosen port
    assign avc_unavailable = ((masked_ovc_request & ~ESC_MASK) == '0);

    assign swap_next = pending_request & sel & y_evc_forbidden & avc_unavailable;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            swap_q <= 1'b0;
        end else if (!full_adaptive) begin
            // partial adaptive never swaps
            swap_q <= 1'b0;
        end else begin
            swap_q <= swap_next;
        end
    end

    assign swap_presel = swap_q;

endmodule

//--- vc_request_gen.sv
`timescale 1ns/100ps

`include "vc_req_cfg.svh"

module vc_request_gen
    import vc_req_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  apb_req_t                           apb_req,
    output apb_rsp_t                           apb_rsp,
    input  vc_mask_t  [`PORT_NUM-1:0]          ovc_avail,
    input  route_t    [`PORT_NUM-1:0][`VC_NUM-1:0] route,
    input  vc_mask_t  [`PORT_NUM*`VC_NUM-1:0]  candidate_ovc,
    input  logic      [`PORT_NUM*`VC_NUM-1:0]  ivc_request,
    input  logic      [`PORT_NUM*`VC_NUM-1:0]  ovc_is_assigned,
    input  logic      [`PORT_NUM*`VC_NUM-1:0]  presel_ld,
    output dest_out_t [`PORT_NUM*`VC_NUM-1:0]  dest_port_out,
    output vc_mask_t  [`PORT_NUM*`VC_NUM-1:0]  masked_ovc_request,
    output logic      [`PORT_NUM*`VC_NUM-1:0]  sel
);

    localparam int IVC_NUM = `PORT_NUM * `VC_NUM;

    presel_t presel;
    logic    full_adaptive;

    logic [IVC_NUM-1:0] pending_request;
    logic [IVC_NUM-1:0] y_evc_forbidden;
    logic [IVC_NUM-1:0] swap_presel;

    presel_t      [`PORT_NUM-1:0] port_presel;
    other_avail_t [`PORT_NUM-1:0] port_avail;

    presel_regs regs_i (
        .clk           (clk),
        .reset         (reset),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .presel        (presel),
        .full_adaptive (full_adaptive)
    );

    // only requests still waiting for an OVC
    assign pending_request = ivc_request & ~ovc_is_assigned;

    // each port only sees the quadrants it can route into
    assign port_presel[LOCAL] = presel;
    assign port_presel[EAST]  = {2'b00, presel[1:0]};
    assign port_presel[NORTH] = {1'b0, presel[2], 1'b0, presel[0]};
    assign port_presel[WEST]  = {presel[3:2], 2'b00};
    assign port_presel[SOUTH] = {presel[3], 1'b0, presel[1], 1'b0};

    for (genvar p = 0; p < `PORT_NUM; p++) begin : g_port
        // own direction is served by the local port instead
        assign port_avail[p].x_plus  = (p == int'(EAST))  ? ovc_avail[LOCAL] : ovc_avail[EAST];
        assign port_avail[p].x_minus = (p == int'(WEST))  ? ovc_avail[LOCAL] : ovc_avail[WEST];
        assign port_avail[p].y_plus  = (p == int'(NORTH)) ? ovc_avail[LOCAL] : ovc_avail[NORTH];
        assign port_avail[p].y_minus = (p == int'(SOUTH)) ? ovc_avail[LOCAL] : ovc_avail[SOUTH];
    end

    for (genvar i = 0; i < IVC_NUM; i++) begin : g_ivc
        port_selector #(
            .SW_LOC (i / `VC_NUM)
        ) portsel_i (
            .clk             (clk),
            .reset           (reset),
            .port_presel     (port_presel[i / `VC_NUM]),
            .presel_ld       (presel_ld[i]),
            .swap_presel     (swap_presel[i]),
            .route           (route[i / `VC_NUM][i % `VC_NUM]),
            .sel             (sel[i]),
            .y_evc_forbidden (y_evc_forbidden[i]),
            .dest_port_out   (dest_port_out[i])
        );

        ovc_request_mask mask_i (
            .clk                (clk),
            .reset              (reset),
            .other_avail        (port_avail[i / `VC_NUM]),
            .route              (route[i / `VC_NUM][i % `VC_NUM]),
            .sel                (sel[i]),
            .y_evc_forbidden    (y_evc_forbidden[i]),
            .full_adaptive      (full_adaptive),
            .candidate_ovc      (candidate_ovc[i]),
            .pending_request    (pending_request[i]),
            .masked_ovc_request (masked_ovc_request[i]),
            .swap_presel        (swap_presel[i])
        );
    end

endmodule

//--- tb_vc_request_gen.sv
`timescale 1ns/100ps

`include "vc_req_cfg.svh"

module tb_vc_request_gen
    import vc_req_pkg::*;
;

    localparam int IVC_NUM = `PORT_NUM * `VC_NUM;
    localparam int N_ENTRIES = 16;
    // two APB writes plus three cycles per entry
    localparam int ENTRY_CYCLES = 9;
    // ten register accesses plus reset
    localparam int APB_CYCLES = 36;
    localparam int TIMEOUT_CYCLES = 2 * (N_ENTRIES * ENTRY_CYCLES + APB_CYCLES);
    localparam vc_mask_t ESC = `ESCAPE_VC_MASK;

    typedef struct packed {
        logic [4:0]              ivc;
        route_t                  route;
        presel_t                 presel;
        logic                    fa;
        logic                    preload;
        logic                    req;
        logic                    asg;
        vc_mask_t                cand;
        logic [IVC_NUM-1:0]      avail;
        logic                    exp_sel;
        dest_out_t               exp_dest;
        vc_mask_t                exp_mask;
    } entry_t;

    logic clk;
    logic reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    vc_mask_t  [`PORT_NUM-1:0]              ovc_avail;
    route_t    [`PORT_NUM-1:0][`VC_NUM-1:0] route;
    vc_mask_t  [IVC_NUM-1:0]                candidate_ovc;
    logic      [IVC_NUM-1:0]                ivc_request;
    logic      [IVC_NUM-1:0]                ovc_is_assigned;
    logic      [IVC_NUM-1:0]                presel_ld;
    dest_out_t [IVC_NUM-1:0]                dest_port_out;
    vc_mask_t  [IVC_NUM-1:0]                masked_ovc_request;
    logic      [IVC_NUM-1:0]                sel;

    entry_t tbl [N_ENTRIES];
    presel_t latched_model [IVC_NUM];
    int n_entries;
    int err_count;
    int err_at_start;
    int check_count;
    int test_count;
    int test_fail;
    int cycle_count;
    logic [16:0] lfsr;
    presel_t cur_presel;
    logic cur_fa;
    logic [31:0] rdata;
    logic err;

    vc_request_gen dut_i (
        .clk                (clk),
        .reset              (reset),
        .apb_req            (apb_req),
        .apb_rsp            (apb_rsp),
        .ovc_avail          (ovc_avail),
        .route              (route),
        .candidate_ovc      (candidate_ovc),
        .ivc_request        (ivc_request),
        .ovc_is_assigned    (ovc_is_assigned),
        .presel_ld          (presel_ld),
        .dest_port_out      (dest_port_out),
        .masked_ovc_request (masked_ovc_request),
        .sel                (sel)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic start_test();
        err_at_start = err_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == err_at_start) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_fail++;
            $display("test %0d %s: %0d errors", test_count, name, err_count - err_at_start);
        end
    endtask

    // setup phase, access phase, back to idle
    task automatic apb_xfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rd,
                            output logic slverr);
        @(posedge clk);
        #1;
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = wr;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #1;
        rd = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check("pready", 32'(apb_rsp.pready), 32'd1);
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    // quadrants reachable from each input port
    function automatic presel_t port_view(presel_t p, int own);
        case (own)
            int'(EAST):  return p & 4'b0011;
            int'(NORTH): return p & 4'b0101;
            int'(WEST):  return p & 4'b1100;
            int'(SOUTH): return p & 4'b1010;
            default:     return p;
        endcase
    endfunction

    function automatic logic predict_sel(route_t r, presel_t latched, int own);
        if (r.x_hop && r.y_hop) begin
            return latched[{r.x_plus, r.y_plus}];
        end
        if (!r.x_hop && !r.y_hop) begin
            return (own == int'(NORTH)) || (own == int'(SOUTH));
        end
        return r.y_hop;
    endfunction

    function automatic dest_out_t predict_dest(route_t r, logic s, int own);
        int op;
        logic [4:0] onehot;
        logic [4:0] kept;
        if (!r.x_hop && !r.y_hop) begin
            op = int'(LOCAL);
        end else begin
            op = s ? (r.y_plus ? int'(NORTH) : int'(SOUTH)) : (r.x_plus ? int'(EAST) : int'(WEST));
        end
        onehot = 5'(1) << op;
        // bits above the own port move down by one
        kept = (onehot & ((5'(1) << own) - 5'(1))) | ((onehot >> (own + 1)) << own);
        return kept[3:0];
    endfunction

    function automatic vc_mask_t predict_mask(route_t r, logic s, int own,
                                              logic [IVC_NUM-1:0] avail, vc_mask_t cand,
                                              logic pend, logic fa);
        int dir;
        int src;
        vc_mask_t c;
        dir = s ? (r.y_plus ? int'(NORTH) : int'(SOUTH)) : (r.x_plus ? int'(EAST) : int'(WEST));
        // own direction served by local availability
        src = (dir == own) ? int'(LOCAL) : dir;
        c = (s && fa && r.x_hop && r.y_hop) ? (cand & ~ESC) : cand;
        return pend ? (avail[src*`VC_NUM +: `VC_NUM] & c) : '0;
    endfunction

    task automatic add_entry(input int ivc, input route_t r, input presel_t p, input logic fa,
                             input logic ld, input logic req, input logic asg);
        logic [31:0] v;
        entry_t e;
        e = '0;
        e.ivc = 5'(ivc);
        e.route = r;
        e.presel = p;
        e.fa = fa;
        e.preload = ld;
        e.req = req;
        e.asg = asg;
        rand_bits(`VC_NUM, v);
        e.cand = v[`VC_NUM-1:0];
        rand_bits(IVC_NUM, v);
        e.avail = v[IVC_NUM-1:0];
        tbl[n_entries] = e;
        n_entries++;
    endtask

    task automatic open_all_vcs();
        tbl[n_entries-1].cand = '1;
        tbl[n_entries-1].avail = '1;
    endtask

    // steps the latch model and fills the expected fields
    task automatic predict(input int i);
        entry_t e;
        int own;
        logic pend;
        logic s_old;
        logic swap;
        vc_mask_t m_old;
        presel_t view;
        e = tbl[i];
        own = int'(e.ivc) / `VC_NUM;
        pend = e.req & ~e.asg;
        s_old = predict_sel(e.route, latched_model[e.ivc], own);
        m_old = predict_mask(e.route, s_old, own, e.avail, e.cand, pend, e.fa);
        swap = pend & s_old & e.route.x_hop & e.route.y_hop & e.fa & ((m_old & ~ESC) == '0);
        view = port_view(e.presel, own);
        if (e.preload) begin
            latched_model[e.ivc] = swap ? ~view : view;
        end
        tbl[i].exp_sel = predict_sel(e.route, latched_model[e.ivc], own);
        tbl[i].exp_dest = predict_dest(e.route, tbl[i].exp_sel, own);
        tbl[i].exp_mask = predict_mask(e.route, tbl[i].exp_sel, own, e.avail, e.cand, pend,
                                       e.fa);
    endtask

    task automatic apply_entry(input int i);
        entry_t e;
        logic [31:0] rd;
        logic slverr;
        int ivc;
        e = tbl[i];
        ivc = int'(e.ivc);
        if (e.presel != cur_presel) begin
            apb_xfer(1'b1, `PRESEL_ADDR, 32'(e.presel), rd, slverr);
            cur_presel = e.presel;
        end
        if (e.fa != cur_fa) begin
            apb_xfer(1'b1, `CTRL_ADDR, 32'(e.fa), rd, slverr);
            cur_fa = e.fa;
        end
        @(posedge clk);
        #1;
        route = '0;
        candidate_ovc = '0;
        ivc_request = '0;
        ovc_is_assigned = '0;
        route[ivc / `VC_NUM][ivc % `VC_NUM] = e.route;
        candidate_ovc[ivc] = e.cand;
        ovc_avail = e.avail;
        ivc_request[ivc] = e.req;
        ovc_is_assigned[ivc] = e.asg;
        // swap register samples this route first
        @(posedge clk);
        #1;
        if (e.preload) begin
            presel_ld[ivc] = 1'b1;
            @(posedge clk);
            #1;
            presel_ld = '0;
        end
        #1;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset = 1'b1;
        apb_req = '0;
        ovc_avail = '0;
        route = '0;
        candidate_ovc = '0;
        ivc_request = '0;
        ovc_is_assigned = '0;
        presel_ld = '0;
        lfsr = 17'd68221;
        n_entries = 0;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        test_fail = 0;
        for (int k = 0; k < IVC_NUM; k++) begin
            latched_model[k] = '0;
        end

        // single direction and local routes
        add_entry(0, route_t'(4'b1010), 4'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(5, route_t'(4'b0010), 4'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(9, route_t'(4'b0001), 4'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(14, route_t'(4'b0101), 4'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(18, route_t'(4'b0000), 4'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(7, route_t'(4'b0000), 4'h0, 1'b1, 1'b0, 1'b1, 1'b0);
        add_entry(11, route_t'(4'b1010), 4'h0, 1'b1, 1'b0, 1'b1, 1'b1);
        add_entry(3, route_t'(4'b0001), 4'h0, 1'b1, 1'b0, 1'b0, 1'b0);
        // both directions, latch then rewrite without load
        add_entry(1, route_t'(4'b1111), 4'b1000, 1'b1, 1'b1, 1'b1, 1'b0);
        open_all_vcs();
        add_entry(1, route_t'(4'b1111), 4'b0000, 1'b1, 1'b0, 1'b1, 1'b0);
        open_all_vcs();
        add_entry(6, route_t'(4'b0111), 4'b0010, 1'b1, 1'b1, 1'b1, 1'b0);
        open_all_vcs();
        add_entry(6, route_t'(4'b0111), 4'b0000, 1'b1, 1'b1, 1'b1, 1'b0);
        open_all_vcs();
        // escape VC in full and partial adaptive mode
        add_entry(1, route_t'(4'b1111), 4'b0000, 1'b1, 1'b0, 1'b1, 1'b0);
        open_all_vcs();
        add_entry(1, route_t'(4'b1111), 4'b0000, 1'b0, 1'b0, 1'b1, 1'b0);
        open_all_vcs();
        // y side left with only the escape VC
        add_entry(13, route_t'(4'b1011), 4'b0100, 1'b1, 1'b1, 1'b1, 1'b0);
        open_all_vcs();
        add_entry(13, route_t'(4'b1011), 4'b0100, 1'b1, 1'b1, 1'b1, 1'b0);
        open_all_vcs();
        tbl[n_entries-1].cand = ESC;

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test();
        apb_xfer(1'b0, `PRESEL_ADDR, 32'd0, rdata, err);
        check("prdata presel", rdata, 32'd0);
        apb_xfer(1'b0, `CTRL_ADDR, 32'd0, rdata, err);
        check("prdata ctrl", rdata, 32'd1);
        check("pslverr", 32'(err), 32'd0);
        end_test("apb reset values");

        start_test();
        apb_xfer(1'b1, `PRESEL_ADDR, 32'h5, rdata, err);
        check("pslverr", 32'(err), 32'd0);
        apb_xfer(1'b1, `CTRL_ADDR, 32'h0, rdata, err);
        apb_xfer(1'b0, `PRESEL_ADDR, 32'd0, rdata, err);
        check("prdata presel", rdata, 32'h5);
        apb_xfer(1'b0, `CTRL_ADDR, 32'd0, rdata, err);
        check("prdata ctrl", rdata, 32'h0);
        end_test("apb write and read back");

        start_test();
        apb_xfer(1'b1, 4'd8, 32'hffff_ffff, rdata, err);
        check("pslverr", 32'(err), 32'd1);
        apb_xfer(1'b0, 4'd8, 32'd0, rdata, err);
        check("pslverr", 32'(err), 32'd1);
        apb_xfer(1'b0, `PRESEL_ADDR, 32'd0, rdata, err);
        check("prdata presel", rdata, 32'h5);
        apb_xfer(1'b0, `CTRL_ADDR, 32'd0, rdata, err);
        check("prdata ctrl", rdata, 32'h0);
        end_test("apb unmapped address");
        cur_presel = 4'h5;
        cur_fa = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            start_test();
            predict(i);
            apply_entry(i);
            check($sformatf("sel[%0d]", tbl[i].ivc), 32'(sel[tbl[i].ivc]),
                  32'(tbl[i].exp_sel));
            check($sformatf("dest_port_out[%0d]", tbl[i].ivc),
                  32'(dest_port_out[tbl[i].ivc]), 32'(tbl[i].exp_dest));
            check($sformatf("masked_ovc_request[%0d]", tbl[i].ivc),
                  32'(masked_ovc_request[tbl[i].ivc]), 32'(tbl[i].exp_mask));
            end_test($sformatf("entry %0d ivc %0d", i, tbl[i].ivc));
        end

        $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
                 test_count, test_fail, check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
vc_req_pkg.sv
presel_regs.sv
port_selector.sv
ovc_request_mask.sv
vc_request_gen.sv
tb_vc_request_gen.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := tb_vc_request_gen
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := sim_$(TOP)
SIM_LOG   := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN) | tee $(SIM_LOG)
	grep -F -q '*** PASSED ***' $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
